// ==== Bender.yml ====
package:
  name: sysctl_top

sources:
  - hdl/csr_pkg.sv
  - hdl/sysctl_pkg.sv
  - hdl/gpio_edge_irq.sv
  - hdl/sys_timer.sv
  - hdl/sysctl.sv
  - hdl/irq_ctrl.sv
  - hdl/sysctl_top.sv
  - target: test
    files:
      - bench/tb_sysctl_top.sv

// ==== bench/sysctl_golden.txt ====
# op field1 field2, hex: W addr data, R addr expect, G gpio -, C cycles -, I line expect
# I lines: 0 gpio 1 timer0 2 timer1 (pulse counts), 3 cpu_irq 4 hard_reset (levels)
I 4 0
R 00f 53595343
R 00e 00000a5f
R 005 ffffffff
R 40f 00000000
W 001 0000beef
R 001 0000beef
W 002 00000005
R 002 00000005
W 004 00000002
R 004 00000002
W 009 0000abcd
R 009 0000abcd
W 008 00000002
R 008 00000002
W 004 00000000
W 008 00000000
G 0001 0
I 0 1
R 000 00000001
G 0003 0
C 008 0
I 0 0
R 000 00000003
W 006 00000000
W 005 00000010
W 004 00000001
I 1 1
C 014 0
I 1 0
R 004 00000000
R 006 00000010
R 400 00000003
I 3 0
W 401 00000004
C 004 0
I 3 0
W 401 00000002
I 3 1
W 400 00000001
R 400 00000002
W 400 00000002
R 400 00000000
I 3 0
W 00f 00000000
I 4 1
C 00a 0
I 4 1

// ==== bench/tb_sysctl_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sysctl top testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_sysctl_top import csr_pkg::*, sysctl_pkg::*; ();

	logic                  sys_clk;
	logic                  sys_rst;
	csr_req_t              csr;
	logic [csr_data_w-1:0] csr_do;
	logic [gpio_in_w-1:0]  gpio_inputs;
	logic [gpio_out_w-1:0] gpio_outputs;
	logic [csr_data_w-1:0] capabilities;
	logic                  gpio_irq;
	logic                  timer0_irq;
	logic                  timer1_irq;
	logic                  cpu_irq;
	logic                  hard_reset;
	int                    pulse_cnt [3];	// gpio, timer0, timer1
	int                    errors;
	int                    checks;
	int                    timeouts;
	logic [31:0]           lcg_state;

	sysctl_top sysctl_top_inst (.*);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;	// 8 ns period
	end

	// one count per high cycle, each irq is a single cycle pulse
	always @(posedge sys_clk) begin
		if (!sys_rst) begin
			if (gpio_irq)
				pulse_cnt[0]++;
			if (timer0_irq)
				pulse_cnt[1]++;
			if (timer1_irq)
				pulse_cnt[2]++;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// called on a falling edge, returns on the next one
	task automatic bus_write(input logic [csr_addr_w-1:0] a, input logic [31:0] d);
		csr.a  = a;
		csr.we = 1'b1;
		csr.di = d;
		@(negedge sys_clk);
		csr.we = 1'b0;
	endtask

	task automatic bus_read(input logic [csr_addr_w-1:0] a, output logic [31:0] rd);
		csr.a  = a;
		csr.we = 1'b0;
		@(negedge sys_clk);
		rd = csr_do;	// registered one edge after the address
	endtask

	// lines 0..2 compare pulse counts, 3 and 4 compare levels
	task automatic expect_irq(input int id, input logic [31:0] exp);
		int   t;
		logic lvl;
		t = 0;
		if (id < 3) begin
			while (pulse_cnt[id] < exp && t < 200) begin
				@(negedge sys_clk);
				t++;
			end
			check(pulse_cnt[id], exp, $sformatf("pulse count on line %0d", id));
			pulse_cnt[id] = 0;
		end else begin
			lvl = (id == 3) ? cpu_irq : hard_reset;
			while (lvl !== exp[0] && t < 200) begin
				@(negedge sys_clk);
				lvl = (id == 3) ? cpu_irq : hard_reset;
				t++;
			end
			check(32'(lvl), exp, $sformatf("level on line %0d", id));
		end
		if (t == 200) begin
			timeouts++;
			$display("timed out waiting on interrupt line %0d", id);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// golden replay
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic replay_golden();
		int          fd;
		int          n;
		string       line;
		byte         op;
		logic [31:0] fa;
		logic [31:0] fb;
		logic [31:0] rd;
		fd = $fopen("bench/sysctl_golden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the golden file bench/sysctl_golden.txt");
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line[0] != "#" && $sscanf(line, "%c %h %h", op, fa, fb) == 3) begin
				case (op)
					"W": begin
						bus_write(fa[csr_addr_w-1:0], fb);
						// output register drives the pins directly
						if (fa[csr_addr_w-1:csr_bank_lsb] == bank_sysctl &&
							fa[csr_ofs_w-1:0] == reg_gpio_out)
							check(32'(gpio_outputs), 32'(fb[gpio_out_w-1:0]),
								"gpio_outputs pins");
					end
					"R": begin
						bus_read(fa[csr_addr_w-1:0], rd);
						check(rd, fb, $sformatf("read of address %h", fa[csr_addr_w-1:0]));
					end
					"G": begin
						gpio_inputs = fa[gpio_in_w-1:0];
						@(negedge sys_clk);
					end
					"C": for (int i = 0; i < fa && i < 10000; i++) @(negedge sys_clk);
					"I": expect_irq(int'(fa), fb);
					default: begin
						errors++;
						$display("unknown operation code in golden file: %c", op);
					end
				endcase
			end
		end
		$fclose(fd);
	endtask

	// two sync stages, so the value is on gpio_in after two edges
	task automatic random_gpio();
		logic [31:0] rd;
		for (int i = 0; i < 6; i++) begin
			lcg_state = lcg_next(lcg_state);
			gpio_inputs = lcg_state[31:16];
			repeat (2) @(negedge sys_clk);
			bus_read({bank_sysctl, 6'd0, reg_gpio_in}, rd);
			check(rd, {16'd0, lcg_state[31:16]}, "random gpio readback");
		end
	endtask

	// auto reload with compare 5, window of 4 periods
	task automatic timer1_window();
		logic [31:0] rd;
		bus_write({bank_sysctl, 6'd0, reg_t1_cmp}, 32'd5);
		bus_write({bank_sysctl, 6'd0, reg_t1_cnt}, 32'd1);	// keeps reads inside 1..N
		pulse_cnt[2] = 0;
		bus_write({bank_sysctl, 6'd0, reg_t1_ctrl}, 32'd3);	// en and ar
		for (int i = 0; i < 4 * 5; i++) begin
			bus_read({bank_sysctl, 6'd0, reg_t1_cnt}, rd);
			check(32'(rd >= 1 && rd <= 5), 32'd1, "timer1 counter inside 1..5");
		end
		check(32'(pulse_cnt[2] >= 3 && pulse_cnt[2] <= 5), 32'd1, "timer1 pulses in window");
		bus_write({bank_sysctl, 6'd0, reg_t1_ctrl}, 32'd0);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		sys_rst      = 1'b1;
		csr          = '0;
		gpio_inputs  = '0;
		capabilities = 32'h0000_0a5f;	// golden caps read expects this
		lcg_state    = 32'h2dec_ee39;
		errors       = 0;
		checks       = 0;
		timeouts     = 0;
		foreach (pulse_cnt[i])
			pulse_cnt[i] = 0;
		repeat (10) @(negedge sys_clk);
		sys_rst = 1'b0;
		replay_golden();
		random_gpio();
		timer1_window();
		sys_rst = 1'b1;	// only sys_rst drops the hard reset request
		repeat (2) @(negedge sys_clk);
		sys_rst = 1'b0;
		check(32'(hard_reset), 32'd0, "hard_reset after sys_rst");
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== hdl/csr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// csr bus types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package csr_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int csr_addr_w = 14;	// bits 13:10 pick the bank
	localparam int csr_data_w = 32;	// read and write data

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Driven by the bus master and seen by every bank at once.
	// A write lands on the edge where the request is present,
	// read data for that address follows one cycle later.
	typedef struct packed {
		logic [csr_addr_w-1:0] a;	// word address
		logic                  we;	// write enable
		logic [csr_data_w-1:0] di;	// write data
	} csr_req_t;	// 47 bits

	// bank field position within the address
	localparam int csr_bank_lsb = 10;
	localparam int csr_bank_w   = csr_addr_w - csr_bank_lsb;

	// register offset within a bank
	localparam int csr_ofs_w = 4;

endpackage

// ==== hdl/gpio_edge_irq.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// gpio sync and change irq
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module gpio_edge_irq import csr_pkg::*, sysctl_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  logic [gpio_in_w-1:0]  gpio_inputs,	// asynchronous pins
	input  logic                  out_we,	// decoded write to reg_gpio_out
	input  logic                  irqen_we,	// decoded write to reg_gpio_irqen
	input  logic [csr_data_w-1:0] wdata,
	output logic [gpio_in_w-1:0]  gpio_in,	// synchronized inputs
	output logic [gpio_out_w-1:0] gpio_outputs,
	output logic [gpio_in_w-1:0]  gpio_irqen,
	output logic                  gpio_irq	// one cycle per change
);

	logic [gpio_in_w-1:0] sync0;	// first flop, may go metastable
	logic [gpio_in_w-1:0] in_prev;	// last cycle's synchronized value
	logic [gpio_in_w-1:0] in_diff;

	// two stage synchronizer plus history
	always_ff @(posedge sys_clk) begin
		sync0   <= gpio_inputs;
		gpio_in <= sync0;
		in_prev <= gpio_in;
	end

	assign in_diff = in_prev ^ gpio_in;	// bits that toggled

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// software registers and irq
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			gpio_outputs <= '0;
			gpio_irqen   <= '0;
			gpio_irq     <= 1'b0;
		end else begin
			gpio_irq <= |(in_diff & gpio_irqen);	// only enabled bits count
			if (out_we)
				gpio_outputs <= wdata[gpio_out_w-1:0];
			if (irqen_we)
				gpio_irqen <= wdata[gpio_in_w-1:0];
		end
	end

	// a rising irq was computed from the enable value one cycle earlier
	a_irq_needs_enable: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		$rose(gpio_irq) |-> $past(|gpio_irqen)
	) else $error("gpio_irq rose with every irq enable bit clear");

endmodule

// ==== hdl/irq_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// interrupt controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module irq_ctrl import csr_pkg::*, sysctl_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  csr_req_t              csr,
	output logic [csr_data_w-1:0] csr_do,	// zero when not selected
	input  logic [irq_n-1:0]      irq_src,	// 0 gpio, 1 timer0, 2 timer1
	output logic                  cpu_irq
);

	logic             sel;
	logic             wr_en;
	logic [3:0]       ofs;
	logic [irq_n-1:0] pend;	// sticky
	logic [irq_n-1:0] mask;	// 1 lets the source through
	logic [irq_n-1:0] clr;

	assign sel   = (csr.a[csr_addr_w-1:csr_bank_lsb] == bank_irq);
	assign ofs   = csr.a[csr_ofs_w-1:0];
	assign wr_en = sel & csr.we;
	assign clr   = (wr_en && (ofs == reg_irq_pend)) ? csr.di[irq_n-1:0] : '0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pending, mask, cpu line
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pend    <= '0;
			mask    <= '0;
			cpu_irq <= 1'b0;
		end else begin
			pend    <= (pend & ~clr) | irq_src;	// new pulse beats the clear
			cpu_irq <= |(pend & mask);
			if (wr_en && (ofs == reg_irq_mask))
				mask <= csr.di[irq_n-1:0];
		end
	end

	// readback, one cycle after the address
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else begin
			csr_do <= '0;
			if (sel) begin
				case (ofs)
					reg_irq_pend: csr_do <= csr_data_w'(pend);
					reg_irq_mask: csr_do <= csr_data_w'(mask);
					default:      csr_do <= '0;
				endcase
			end
		end
	end

endmodule

// ==== hdl/sys_timer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// compare timer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module sys_timer import csr_pkg::*, sysctl_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  timer_wr_t   wr,	// decoded csr writes
	output timer_stat_t stat,	// readback
	output logic        irq	// one cycle on match
);

	logic                  en;
	logic                  ar;	// reload to 1 on match
	logic [csr_data_w-1:0] compare;
	logic [csr_data_w-1:0] counter;
	logic                  match;

	assign match = (counter == compare);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// count and match
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			en      <= 1'b0;
			ar      <= 1'b0;
			compare <= '1;	// far away until software sets it
			counter <= '0;
			irq     <= 1'b0;
		end else begin
			irq <= en & match;
			if (en & ~match)
				counter <= counter + 1'b1;
			if (en & ar & match)
				counter <= 1;	// period equals compare
			if (~ar & match)
				en <= 1'b0;	// one shot stops, counter holds

			// software writes come last so they take priority
			if (wr.ctrl_we) begin
				en <= wr.data[0];
				ar <= wr.data[1];
			end
			if (wr.cmp_we)
				compare <= wr.data;
			if (wr.cnt_we)
				counter <= wr.data;	// beats the reload
		end
	end

	assign stat.en      = en;
	assign stat.ar      = ar;
	assign stat.compare = compare;
	assign stat.counter = counter;

	// back to back matches only when reloading onto a compare of 1
	a_irq_single: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		irq |=> !irq || (ar && compare == 1)
	) else $error("timer irq held for two cycles");

endmodule

// ==== hdl/sysctl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system control bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module sysctl import csr_pkg::*, sysctl_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  csr_req_t              csr,
	output logic [csr_data_w-1:0] csr_do,	// zero when not selected
	input  logic [gpio_in_w-1:0]  gpio_inputs,
	output logic [gpio_out_w-1:0] gpio_outputs,
	input  logic [csr_data_w-1:0] capabilities,
	output logic                  gpio_irq,
	output logic                  timer0_irq,
	output logic                  timer1_irq,
	output logic                  hard_reset	// sticky until sys_rst
);

	logic                 sel;	// our bank addressed
	logic                 wr_en;
	logic [3:0]           ofs;
	logic [gpio_in_w-1:0] gpio_in;
	logic [gpio_in_w-1:0] gpio_irqen;
	timer_wr_t            t0_wr;
	timer_wr_t            t1_wr;
	timer_stat_t          t0_stat;
	timer_stat_t          t1_stat;

	assign sel   = (csr.a[csr_addr_w-1:csr_bank_lsb] == bank_sysctl);
	assign ofs   = csr.a[csr_ofs_w-1:0];
	assign wr_en = sel & csr.we;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write strobes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign t0_wr.ctrl_we = wr_en && (ofs == reg_t0_ctrl);
	assign t0_wr.cmp_we  = wr_en && (ofs == reg_t0_cmp);
	assign t0_wr.cnt_we  = wr_en && (ofs == reg_t0_cnt);
	assign t0_wr.data    = csr.di;
	assign t1_wr.ctrl_we = wr_en && (ofs == reg_t1_ctrl);
	assign t1_wr.cmp_we  = wr_en && (ofs == reg_t1_cmp);
	assign t1_wr.cnt_we  = wr_en && (ofs == reg_t1_cnt);
	assign t1_wr.data    = csr.di;

	gpio_edge_irq gpio_inst (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.gpio_inputs  (gpio_inputs),
		.out_we       (wr_en && (ofs == reg_gpio_out)),
		.irqen_we     (wr_en && (ofs == reg_gpio_irqen)),
		.wdata        (csr.di),
		.gpio_in      (gpio_in),
		.gpio_outputs (gpio_outputs),
		.gpio_irqen   (gpio_irqen),
		.gpio_irq     (gpio_irq)
	);

	sys_timer timer0_inst (.sys_clk(sys_clk), .sys_rst(sys_rst), .wr(t0_wr),
		.stat(t0_stat), .irq(timer0_irq));

	sys_timer timer1_inst (.sys_clk(sys_clk), .sys_rst(sys_rst), .wr(t1_wr),
		.stat(t1_stat), .irq(timer1_irq));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// readback and hard reset
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do     <= '0;
			hard_reset <= 1'b0;
		end else begin
			if (wr_en && (ofs == reg_sysid))
				hard_reset <= 1'b1;	// picked up by the reset generator
			csr_do <= '0;
			if (sel) begin
				case (ofs)
					reg_gpio_in:    csr_do <= csr_data_w'(gpio_in);
					reg_gpio_out:   csr_do <= csr_data_w'(gpio_outputs);
					reg_gpio_irqen: csr_do <= csr_data_w'(gpio_irqen);
					reg_t0_ctrl:    csr_do <= csr_data_w'({t0_stat.ar, t0_stat.en});
					reg_t0_cmp:     csr_do <= t0_stat.compare;
					reg_t0_cnt:     csr_do <= t0_stat.counter;
					reg_t1_ctrl:    csr_do <= csr_data_w'({t1_stat.ar, t1_stat.en});
					reg_t1_cmp:     csr_do <= t1_stat.compare;
					reg_t1_cnt:     csr_do <= t1_stat.counter;
					reg_caps:       csr_do <= capabilities;
					reg_sysid:      csr_do <= system_id;
					default:        csr_do <= '0;	// holes read zero
				endcase
			end
		end
	end

	// the top level ORs bank outputs, so a foreign request must read as zero
	a_do_quiet: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		(csr.a[csr_addr_w-1:csr_bank_lsb] != bank_sysctl) |=> (csr_do == '0)
	) else $error("sysctl drove read data for another bank");

endmodule

// ==== hdl/sysctl_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system control register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sysctl_pkg;
	import csr_pkg::*;

	// bank numbers, compared with a[13:10]
	localparam logic [3:0] bank_sysctl = 4'd0;
	localparam logic [3:0] bank_irq    = 4'd1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// offsets
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [3:0] reg_gpio_in    = 4'd0;	// read only
	localparam logic [3:0] reg_gpio_out   = 4'd1;
	localparam logic [3:0] reg_gpio_irqen = 4'd2;
	localparam logic [3:0] reg_t0_ctrl    = 4'd4;	// bit0 en, bit1 ar
	localparam logic [3:0] reg_t0_cmp     = 4'd5;
	localparam logic [3:0] reg_t0_cnt     = 4'd6;
	localparam logic [3:0] reg_t1_ctrl    = 4'd8;
	localparam logic [3:0] reg_t1_cmp     = 4'd9;
	localparam logic [3:0] reg_t1_cnt     = 4'd10;
	localparam logic [3:0] reg_caps       = 4'd14;
	localparam logic [3:0] reg_sysid      = 4'd15;	// write requests hard reset
	localparam logic [3:0] reg_irq_pend   = 4'd0;	// irq bank, write 1 to clear
	localparam logic [3:0] reg_irq_mask   = 4'd1;	// irq bank

	localparam int gpio_in_w  = 16;
	localparam int gpio_out_w = 16;
	localparam int irq_n      = 3;	// gpio, timer0, timer1

	localparam logic [csr_data_w-1:0] system_id = 32'h5359_5343;

	// decoded timer writes, one strobe per register
	typedef struct packed {
		logic                  ctrl_we;
		logic                  cmp_we;
		logic                  cnt_we;
		logic [csr_data_w-1:0] data;
	} timer_wr_t;

	// timer state for readback
	typedef struct packed {
		logic                  en;
		logic                  ar;
		logic [csr_data_w-1:0] compare;
		logic [csr_data_w-1:0] counter;
	} timer_stat_t;	// 66 bits

endpackage

// ==== hdl/sysctl_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system control top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module sysctl_top import csr_pkg::*, sysctl_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  csr_req_t              csr,	// shared by both banks
	output logic [csr_data_w-1:0] csr_do,
	input  logic [gpio_in_w-1:0]  gpio_inputs,
	output logic [gpio_out_w-1:0] gpio_outputs,
	input  logic [csr_data_w-1:0] capabilities,
	output logic                  gpio_irq,
	output logic                  timer0_irq,
	output logic                  timer1_irq,
	output logic                  cpu_irq,
	output logic                  hard_reset
);

	logic [csr_data_w-1:0] sysctl_do;
	logic [csr_data_w-1:0] irq_do;

	sysctl sysctl_inst (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.csr          (csr),
		.csr_do       (sysctl_do),
		.gpio_inputs  (gpio_inputs),
		.gpio_outputs (gpio_outputs),
		.capabilities (capabilities),
		.gpio_irq     (gpio_irq),
		.timer0_irq   (timer0_irq),
		.timer1_irq   (timer1_irq),
		.hard_reset   (hard_reset)
	);

	irq_ctrl irq_ctrl_inst (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.csr     (csr),
		.csr_do  (irq_do),
		.irq_src ({timer1_irq, timer0_irq, gpio_irq}),	// matches pending bit order
		.cpu_irq (cpu_irq)
	);

	assign csr_do = sysctl_do | irq_do;	// unselected bank reads zero

endmodule

// ==== sysctl_top.f ====
hdl/csr_pkg.sv
hdl/sysctl_pkg.sv
hdl/gpio_edge_irq.sv
hdl/sys_timer.sv
hdl/sysctl.sv
hdl/irq_ctrl.sv
hdl/sysctl_top.sv
bench/tb_sysctl_top.sv
